//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_riscv_core
FILELIST  ?= riscv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

    localparam int XLEN       = 32; // Data and address width
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0; // Fetch address after reset

endpackage

`default_nettype wire

//--- common/ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if import riscv_isa_pkg::*; ();

    logic        reg_write;
    logic        mem_write;
    logic        alu_src;     // 1 selects the immediate as ALU operand b
    imm_src_e    imm_src;
    result_src_e result_src;
    alu_op_e     alu_op;
    logic        pc_src;      // 1 takes PC plus immediate
    logic        jalr_pc_src; // 1 takes the ALU result with bit 0 cleared

    modport ctrl (
        output reg_write, mem_write, alu_src, imm_src, result_src,
        output alu_op, pc_src, jalr_pc_src
    );

    modport dp (
        input reg_write, mem_write, alu_src, imm_src, result_src,
        input alu_op, pc_src, jalr_pc_src
    );

endinterface

`default_nettype wire

//--- common/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } imm_src_e;

    typedef enum logic [1:0] {
        ALU_CLASS_ADD    = 2'b00, // Address computation
        ALU_CLASS_SUB    = 2'b01, // Branch compare
        ALU_CLASS_FUNCT  = 2'b10, // Decided by funct3
        ALU_CLASS_PASS_B = 2'b11  // LUI
    } alu_class_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'b000,
        ALU_SUB    = 3'b001,
        ALU_AND    = 3'b010,
        ALU_OR     = 3'b011,
        ALU_SLT    = 3'b100,
        ALU_PASS_B = 3'b101
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU         = 2'b00,
        RES_MEM         = 2'b01,
        RES_PC_PLUS4    = 2'b10, // Link value of JAL and JALR
        RES_PC_PLUS_IMM = 2'b11  // AUIPC
    } result_src_e;

    localparam logic [2:0] FUNCT3_BEQ = 3'b000;
    localparam logic [2:0] FUNCT3_BNE = 3'b001;

    // Arithmetic funct3 values, shared by OP and OP_IMM
    localparam logic [2:0] FUNCT3_ADD = 3'b000;
    localparam logic [2:0] FUNCT3_SLT = 3'b010;
    localparam logic [2:0] FUNCT3_OR  = 3'b110;
    localparam logic [2:0] FUNCT3_AND = 3'b111;

endpackage

`default_nettype wire

//--- control_unit/alu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decoder import riscv_isa_pkg::*; (
    input  alu_class_e alu_class_i,
    input  logic [2:0] funct3_i,
    input  logic       funct7b5_i,
    input  logic       op_b5_i,     // Set for OP, clear for OP_IMM
    output alu_op_e    alu_op_o
);

    always_comb
    begin
        case (alu_class_i)
            ALU_CLASS_ADD:    alu_op_o = ALU_ADD;
            ALU_CLASS_SUB:    alu_op_o = ALU_SUB;
            ALU_CLASS_PASS_B: alu_op_o = ALU_PASS_B;
            default:
            begin
                case (funct3_i)
                    // ADDI has no funct7, so bit 30 there is immediate data
                    FUNCT3_ADD: alu_op_o = (op_b5_i && funct7b5_i) ? ALU_SUB : ALU_ADD;
                    FUNCT3_SLT: alu_op_o = ALU_SLT;
                    FUNCT3_OR:  alu_op_o = ALU_OR;
                    FUNCT3_AND: alu_op_o = ALU_AND;
                    default:    alu_op_o = ALU_ADD; // Unsupported funct3
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

//--- control_unit/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import riscv_isa_pkg::*, core_cfg_pkg::*; (
    input  logic [XLEN-1:0] instr_i,
    input  logic            eq_i,
    ctrl_if.ctrl            ctrl
);

    opcode_e    op;
    alu_class_e alu_class; // Between the two decoders

    assign op = opcode_e'(instr_i[6:0]);

    main_decoder u_main_decoder (
        .eq_i          (eq_i),
        .op_i          (op),
        .funct3_i      (instr_i[14:12]),
        .reg_write_o   (ctrl.reg_write),
        .mem_write_o   (ctrl.mem_write),
        .alu_src_o     (ctrl.alu_src),
        .imm_src_o     (ctrl.imm_src),
        .result_src_o  (ctrl.result_src),
        .alu_class_o   (alu_class),
        .pc_src_o      (ctrl.pc_src),
        .jalr_pc_src_o (ctrl.jalr_pc_src)
    );

    alu_decoder u_alu_decoder (
        .alu_class_i (alu_class),
        .funct3_i    (instr_i[14:12]),
        .funct7b5_i  (instr_i[30]),
        .op_b5_i     (instr_i[5]),
        .alu_op_o    (ctrl.alu_op)
    );

endmodule

`default_nettype wire

//--- control_unit/main_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module main_decoder import riscv_isa_pkg::*; (
    input  logic        eq_i,          // Register operands equal
    input  opcode_e     op_i,
    input  logic [2:0]  funct3_i,

    output logic        reg_write_o,
    output logic        mem_write_o,
    output logic        alu_src_o,     // 1 - immediate as ALU operand b
    output imm_src_e    imm_src_o,
    output result_src_e result_src_o,
    output alu_class_e  alu_class_o,
    output logic        pc_src_o,      // 1 - PC plus immediate
    output logic        jalr_pc_src_o  // 1 - ALU result as next PC
);

    logic branch; // Conditional branch
    logic jal;    // Unconditional PC-relative jump

    // Defaults describe a harmless no-op, each opcode overrides what it needs
    always_comb
    begin
        reg_write_o   = 1'b0;
        mem_write_o   = 1'b0;
        alu_src_o     = 1'b0;
        imm_src_o     = IMM_I;
        result_src_o  = RES_ALU;
        alu_class_o   = ALU_CLASS_ADD;
        jalr_pc_src_o = 1'b0;
        branch        = 1'b0;
        jal           = 1'b0;
        case (op_i)
            OPC_LOAD:
            begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = RES_MEM;
            end
            OPC_STORE:
            begin
                mem_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = IMM_S;
            end
            OPC_OP:
            begin
                reg_write_o = 1'b1;
                alu_class_o = ALU_CLASS_FUNCT;
            end
            OPC_OP_IMM:
            begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_class_o = ALU_CLASS_FUNCT;
            end
            OPC_BRANCH:
            begin
                imm_src_o   = IMM_B;
                alu_class_o = ALU_CLASS_SUB;
                branch      = 1'b1;
            end
            OPC_JAL:
            begin
                reg_write_o  = 1'b1;
                imm_src_o    = IMM_J;
                result_src_o = RES_PC_PLUS4; // Link
                jal          = 1'b1;
            end
            OPC_JALR:
            begin
                reg_write_o   = 1'b1;
                alu_src_o     = 1'b1;         // rs1 + imm gives the target
                result_src_o  = RES_PC_PLUS4;
                jalr_pc_src_o = 1'b1;
            end
            OPC_LUI:
            begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = IMM_U;
                alu_class_o = ALU_CLASS_PASS_B;
            end
            OPC_AUIPC:
            begin
                reg_write_o  = 1'b1;
                imm_src_o    = IMM_U;
                result_src_o = RES_PC_PLUS_IMM; // Adder outside the ALU
            end
            default: ; // Unknown opcode keeps the defaults
        endcase
    end

    always_comb
    begin
        if (jal)
            pc_src_o = 1'b1;
        else if (branch && funct3_i == FUNCT3_BEQ)
            pc_src_o = eq_i;
        else if (branch && funct3_i == FUNCT3_BNE)
            pc_src_o = !eq_i;
        else
            pc_src_o = 1'b0; // Sequential flow
    end

endmodule

`default_nettype wire

//--- hw/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import riscv_isa_pkg::*, core_cfg_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic [XLEN-1:0] instr_i,
    input  logic [XLEN-1:0] dmem_rdata_i,
    ctrl_if.dp              ctrl,
    output logic            eq_o,
    output logic [XLEN-1:0] imem_addr_o,
    output logic [XLEN-1:0] dmem_addr_o,
    output logic [XLEN-1:0] dmem_wdata_o,
    output logic            dmem_we_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_plus_imm; // Branch, JAL and AUIPC target
    logic            run_q;       // Low until the first clock after reset
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] result;
    logic            rd_we;

    // Immediate extension by format
    always_comb
    begin
        case (ctrl.imm_src)
            IMM_I:   imm = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
            IMM_S:   imm = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            IMM_B:   imm = {{(XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                            instr_i[11:8], 1'b0};
            IMM_J:   imm = {{(XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                            instr_i[30:21], 1'b0};
            IMM_U:   imm = {instr_i[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    assign rd_we = ctrl.reg_write && run_q;

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (instr_i[19:15]),
        .rs2_addr_i (instr_i[24:20]),
        .rd_addr_i  (instr_i[11:7]),
        .rd_we_i    (rd_we),
        .rd_data_i  (result),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    assign alu_b = ctrl.alu_src ? imm : rs2_data;

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_result = rs1_data + alu_b;
            ALU_SUB:    alu_result = rs1_data - alu_b;
            ALU_AND:    alu_result = rs1_data & alu_b;
            ALU_OR:     alu_result = rs1_data | alu_b;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(rs1_data) < $signed(alu_b)};
            ALU_PASS_B: alu_result = alu_b; // LUI
            default:    alu_result = '0;
        endcase
    end

    assign eq_o = (rs1_data == rs2_data); // Independent of the ALU operation

    assign pc_plus4    = pc_q + XLEN'(4);
    assign pc_plus_imm = pc_q + imm;

    // Write-back selection
    always_comb
    begin
        case (ctrl.result_src)
            RES_ALU:         result = alu_result;
            RES_MEM:         result = dmem_rdata_i;
            RES_PC_PLUS4:    result = pc_plus4;
            RES_PC_PLUS_IMM: result = pc_plus_imm;
            default:         result = alu_result;
        endcase
    end

    always_comb
    begin
        if (ctrl.jalr_pc_src)
            pc_next = {alu_result[XLEN-1:1], 1'b0};
        else if (ctrl.pc_src)
            pc_next = pc_plus_imm;
        else
            pc_next = pc_plus4;
    end

    // The PC holds at RESET_PC for the cycle in which run_q rises,
    // so the first instruction then executes with its writes enabled
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            run_q <= 1'b0;
            pc_q  <= RESET_PC;
        end
        else
        begin
            run_q <= 1'b1;
            if (run_q)
                pc_q <= pc_next;
        end
    end

    assign imem_addr_o  = pc_q;
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rs2_data;
    assign dmem_we_o    = ctrl.mem_write && run_q; // Low throughout reset

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_cfg_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic                  rd_we_i,
    input  logic [XLEN-1:0]       rd_data_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    logic [XLEN-1:0] regs_q [NUM_REGS-1:1]; // No storage for x0

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            for (int i = 1; i < NUM_REGS; i++)
                regs_q[i] <= '0;
        end
        else if (rd_we_i && rd_addr_i != '0)
            regs_q[rd_addr_i] <= rd_data_i;
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

//--- hw/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core import core_cfg_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic [XLEN-1:0] instr_i,      // Fetched word at imem_addr_o
    input  logic [XLEN-1:0] dmem_rdata_i, // Same-cycle load data
    output logic [XLEN-1:0] imem_addr_o,
    output logic [XLEN-1:0] dmem_addr_o,
    output logic [XLEN-1:0] dmem_wdata_o,
    output logic            dmem_we_o
);

    logic eq; // Branch compare result

    ctrl_if u_ctrl_if ();

    control_unit u_control_unit (
        .instr_i (instr_i),
        .eq_i    (eq),
        .ctrl    (u_ctrl_if.ctrl)
    );

    datapath u_datapath (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .instr_i      (instr_i),
        .dmem_rdata_i (dmem_rdata_i),
        .ctrl         (u_ctrl_if.dp),
        .eq_o         (eq),
        .imem_addr_o  (imem_addr_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o)
    );

endmodule

`default_nettype wire

//--- riscv_core.f
+incdir+verif
common/riscv_isa_pkg.sv
common/core_cfg_pkg.sv
common/ctrl_if.sv
control_unit/main_decoder.sv
control_unit/alu_decoder.sv
control_unit/control_unit.sv
hw/reg_file.sv
hw/datapath.sv
hw/riscv_core.sv
verif/tb_riscv_core.sv

//--- verif/riscv_iss.svh
`ifndef RISCV_ISS_SVH
`define RISCV_ISS_SVH

// Instruction-level model, one call of step_model per executed instruction
logic [XLEN-1:0] ref_pc;
logic [XLEN-1:0] ref_regs [NUM_REGS];
logic [XLEN-1:0] ref_mem  [MEM_WORDS];

function automatic logic [XLEN-1:0] alu_model(input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b,
                                              input logic [2:0]      f3,
                                              input logic            sub);
    case (f3)
        FUNCT3_SLT: return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
        FUNCT3_OR:  return a | b;
        FUNCT3_AND: return a & b;
        default:    return sub ? a - b : a + b;
    endcase
endfunction

task automatic reset_model();
    ref_pc = RESET_PC;
    for (int r = 0; r < NUM_REGS; r++)
        ref_regs[r] = '0;
endtask

task automatic step_model(input logic [XLEN-1:0] ins, output logic st_we,
                          output logic [XLEN-1:0] st_addr, output logic [XLEN-1:0] st_data);
    opcode_e         op;
    logic [4:0]      rd;
    logic [2:0]      f3;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] wb;
    logic [XLEN-1:0] next_pc;
    logic            wr;
    op      = opcode_e'(ins[6:0]);
    rd      = ins[11:7];
    f3      = ins[14:12];
    a       = ref_regs[ins[19:15]];
    b       = ref_regs[ins[24:20]];
    i_imm   = {{20{ins[31]}}, ins[31:20]};
    s_imm   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    b_imm   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    j_imm   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    wb      = '0;
    wr      = 1'b0;
    st_we   = 1'b0;
    st_addr = '0;
    st_data = '0;
    next_pc = ref_pc + XLEN'(4);
    case (op)
        OPC_LOAD:   begin wb = ref_mem[(a + i_imm) >> 2]; wr = 1'b1; end
        OPC_STORE:
        begin
            st_we   = 1'b1;
            st_addr = a + s_imm;
            st_data = b;
            ref_mem[st_addr[7:2]] = b;
        end
        OPC_OP:     begin wb = alu_model(a, b, f3, ins[30]); wr = 1'b1; end
        OPC_OP_IMM: begin wb = alu_model(a, i_imm, f3, 1'b0); wr = 1'b1; end
        OPC_BRANCH:
        begin
            if ((f3 == FUNCT3_BEQ && a == b) || (f3 == FUNCT3_BNE && a != b))
                next_pc = ref_pc + b_imm;
        end
        OPC_JAL:    begin wb = ref_pc + XLEN'(4); wr = 1'b1; next_pc = ref_pc + j_imm; end
        OPC_JALR:
        begin
            wb      = ref_pc + XLEN'(4);
            wr      = 1'b1;
            next_pc = (a + i_imm) & ~XLEN'(1); // Target bit 0 dropped
        end
        OPC_LUI:    begin wb = {ins[31:12], 12'b0}; wr = 1'b1; end
        OPC_AUIPC:  begin wb = ref_pc + {ins[31:12], 12'b0}; wr = 1'b1; end
        default: ;
    endcase
    if (wr && rd != 5'd0)
        ref_regs[rd] = wb;
    ref_pc = next_pc;
endtask

`endif

//--- verif/tb_riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core import riscv_isa_pkg::*, core_cfg_pkg::*; ();

    localparam int MEM_WORDS      = 64;
    localparam int RAND_LEN       = 32; // Random part of the program
    localparam int SWEEP_REGS     = 15; // x1..x15 are the only registers used
    localparam int PROG_LEN       = 48;
    localparam int SWEEP_BASE     = 48; // Data word of the x1 dump
    localparam int TIMEOUT_CYCLES = 200;
    localparam logic [XLEN-1:0] END_PC = XLEN'((PROG_LEN - 1) * 4);

    logic            clk;
    logic            arst_n;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] dmem_rdata;
    logic [XLEN-1:0] imem_addr;
    logic [XLEN-1:0] dmem_addr;
    logic [XLEN-1:0] dmem_wdata;
    logic            dmem_we;
    logic [XLEN-1:0] imem [MEM_WORDS];
    logic [XLEN-1:0] dmem [MEM_WORDS];
    bit              jalr_slot [MEM_WORDS]; // Set where a JALR follows its ADDI
    int unsigned     cycles = 0;

    `include "riscv_iss.svh"

    riscv_core dut (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .instr_i      (instr),
        .dmem_rdata_i (dmem_rdata),
        .imem_addr_o  (imem_addr),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we)
    );

    always #20 clk = ~clk;

    assign instr      = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk)
    begin
        if (dmem_we)
            dmem[dmem_addr[7:2]] <= dmem_wdata;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Stopped at the first error");
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
            fail_now("Timeout, the program never reached its final self jump");
    end

    task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        if (got !== exp)
            fail_now($sformatf("FAIL t=%0t imem_addr_o got %h expected %h", $time, got, exp));
    endtask

    task automatic check_store(input logic got_we, input logic exp_we,
                               input logic [XLEN-1:0] got_addr, input logic [XLEN-1:0] exp_addr,
                               input logic [XLEN-1:0] got_data, input logic [XLEN-1:0] exp_data);
        if (got_we !== exp_we)
            fail_now($sformatf("FAIL t=%0t dmem_we_o got %b expected %b", $time, got_we, exp_we));
        if (exp_we && got_addr !== exp_addr)
            fail_now($sformatf("FAIL t=%0t dmem_addr_o got %h expected %h",
                               $time, got_addr, exp_addr));
        if (exp_we && got_data !== exp_data)
            fail_now($sformatf("FAIL t=%0t dmem_wdata_o got %h expected %h",
                               $time, got_data, exp_data));
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp)
            fail_now($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'($urandom_range(SWEEP_REGS, 0));
    endfunction

    function automatic logic [2:0] pick_alu_funct3();
        case ($urandom_range(3, 0))
            0:       return FUNCT3_ADD;
            1:       return FUNCT3_SLT;
            2:       return FUNCT3_OR;
            default: return FUNCT3_AND;
        endcase
    endfunction

    // Forward target that never lands between an ADDI and its JALR
    function automatic int pick_target(input int lo);
        int tgt;
        tgt = $urandom_range(RAND_LEN, lo);
        if (jalr_slot[tgt])
            tgt--;
        return tgt;
    endfunction

    // Random body, then a dump of x1..x15, then a self jump
    task automatic build_program();
        int         i;
        int         tgt;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] base;
        logic [2:0] f3;
        for (int k = 0; k < MEM_WORDS; k++)
        begin
            imem[k]      = '0;
            jalr_slot[k] = 1'b0;
        end
        // Filled from the end, so every forward target is already known
        i = RAND_LEN - 1;
        while (i >= 0)
        begin
            rd  = pick_reg();
            rs1 = pick_reg();
            rs2 = pick_reg();
            f3  = pick_alu_funct3();
            case ($urandom_range(9, 0))
                0: imem[i] = enc_i(12'(4 * $urandom_range(31, 0)), 5'd0, 3'b010, rd, OPC_LOAD);
                1: imem[i] = enc_s(12'(4 * $urandom_range(31, 0)), rs2, 5'd0);
                3: imem[i] = enc_i(12'($urandom), rs1, f3, rd, OPC_OP_IMM);
                4:
                begin
                    tgt     = pick_target(i + 1);
                    imem[i] = enc_b(13'((tgt - i) * 4), rs2, rs1,
                                    ($urandom_range(1, 0) == 1) ? FUNCT3_BNE : FUNCT3_BEQ);
                end
                5:
                begin
                    tgt     = pick_target(i + 1);
                    imem[i] = enc_j(21'((tgt - i) * 4), rd);
                end
                6:
                begin
                    if (i > 0)
                    begin
                        tgt          = pick_target(i + 1);
                        base         = 5'($urandom_range(SWEEP_REGS, 1));
                        imem[i - 1]  = enc_i(12'(tgt * 4 + 1), 5'd0, FUNCT3_ADD, base,
                                             OPC_OP_IMM);
                        imem[i]      = enc_i(12'd0, base, 3'b000, rd, OPC_JALR);
                        jalr_slot[i] = 1'b1;
                        i--;
                    end
                    else
                        imem[i] = {20'($urandom), rd, OPC_LUI};
                end
                7: imem[i] = {20'($urandom), rd, OPC_LUI};
                8: imem[i] = {20'($urandom), rd, OPC_AUIPC};
                default:
                begin
                    imem[i] = {(f3 == FUNCT3_ADD && $urandom_range(1, 0) == 1) ? 7'b0100000 : 7'b0,
                               rs2, rs1, f3, rd, OPC_OP};
                end
            endcase
            i--;
        end
        for (int r = 1; r <= SWEEP_REGS; r++)
            imem[RAND_LEN + r - 1] = enc_s(12'((SWEEP_BASE + r - 1) * 4), 5'(r), 5'd0);
        imem[PROG_LEN - 1] = enc_j(21'd0, 5'd0);
    endtask

    initial
    begin
        logic            exp_we;
        logic [XLEN-1:0] exp_addr;
        logic [XLEN-1:0] exp_data;
        logic            at_end;
        void'($urandom(32'he649e074));
        clk    = 1'b0;
        arst_n <= 1'b0;
        for (int k = 0; k < MEM_WORDS; k++)
        begin
            ref_mem[k] = 32'h3c6ef35f ^ (32'(k) * 32'h9e3779b9);
            dmem[k]    <= ref_mem[k];
        end
        build_program();
        reset_model();

        repeat (3)
        begin
            @(posedge clk);
            @(negedge clk);
            check_pc(imem_addr, RESET_PC);
            check_store(dmem_we, 1'b0, dmem_addr, '0, dmem_wdata, '0);
        end
        @(posedge clk);
        arst_n <= 1'b1;

        // Run flag still low, so nothing may be written yet
        @(negedge clk);
        check_pc(imem_addr, RESET_PC);
        check_store(dmem_we, 1'b0, dmem_addr, '0, dmem_wdata, '0);
        @(posedge clk);

        do
        begin
            @(negedge clk);
            check_pc(imem_addr, ref_pc);
            at_end = (ref_pc == END_PC);
            step_model(imem[ref_pc[7:2]], exp_we, exp_addr, exp_data);
            check_store(dmem_we, exp_we, dmem_addr, exp_addr, dmem_wdata, exp_data);
            @(posedge clk);
        end
        while (!at_end);

        @(negedge clk);
        check_pc(imem_addr, END_PC);
        for (int k = 0; k < MEM_WORDS; k++)
            check_word($sformatf("dmem[%0d]", k), dmem[k], ref_mem[k]);
        for (int r = 1; r <= SWEEP_REGS; r++)
            check_word($sformatf("x%0d dump", r), dmem[SWEEP_BASE + r - 1], ref_regs[r]);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
